//--- include/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Needs la_decode_pkg imported in the including scope

typedef struct packed {
    la_op_e      op;
    logic [4:0]  rk;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [31:0] imm;
} decode_exp_t;

// 1 3R, 2 2RI5, 3 signed 2RI12, 4 unsigned 2RI12, 5 1RI20, 6 offs16, 7 offs26
function automatic int op_group(input la_op_e op);
    case (op)
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_NOR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA: return 1;
        OP_SLLI, OP_SRLI, OP_SRAI: return 2;
        OP_ADDI, OP_SLTI, OP_SLTUI, OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU,
        OP_STB, OP_STH, OP_STW: return 3;
        OP_ANDI, OP_ORI, OP_XORI: return 4;
        OP_LU12I, OP_PCADDU12I: return 5;
        OP_JIRL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: return 6;
        OP_B, OP_BL: return 7;
        default: return 0;
    endcase
endfunction

// Low bit of the opcode field and its code, lo 0 for whole-word codes
function automatic void op_field(input la_op_e op, output int lo, output logic [31:0] code);
    case (op_group(op))
        1, 2: lo = 15;
        3, 4: lo = 22;
        5: lo = 25;
        6, 7: lo = 26;
        default: lo = 0;
    endcase
    case (op)
        OP_ADD:       code = 32'(CODE_ADD);
        OP_SUB:       code = 32'(CODE_SUB);
        OP_SLT:       code = 32'(CODE_SLT);
        OP_SLTU:      code = 32'(CODE_SLTU);
        OP_NOR:       code = 32'(CODE_NOR);
        OP_AND:       code = 32'(CODE_AND);
        OP_OR:        code = 32'(CODE_OR);
        OP_XOR:       code = 32'(CODE_XOR);
        OP_SLL:       code = 32'(CODE_SLL);
        OP_SRL:       code = 32'(CODE_SRL);
        OP_SRA:       code = 32'(CODE_SRA);
        OP_SLLI:      code = 32'(CODE_SLLI);
        OP_SRLI:      code = 32'(CODE_SRLI);
        OP_SRAI:      code = 32'(CODE_SRAI);
        OP_SLTI:      code = 32'(CODE_SLTI);
        OP_SLTUI:     code = 32'(CODE_SLTUI);
        OP_ADDI:      code = 32'(CODE_ADDI);
        OP_ANDI:      code = 32'(CODE_ANDI);
        OP_ORI:       code = 32'(CODE_ORI);
        OP_XORI:      code = 32'(CODE_XORI);
        OP_LDB:       code = 32'(CODE_LDB);
        OP_LDH:       code = 32'(CODE_LDH);
        OP_LDW:       code = 32'(CODE_LDW);
        OP_STB:       code = 32'(CODE_STB);
        OP_STH:       code = 32'(CODE_STH);
        OP_STW:       code = 32'(CODE_STW);
        OP_LDBU:      code = 32'(CODE_LDBU);
        OP_LDHU:      code = 32'(CODE_LDHU);
        OP_LU12I:     code = 32'(CODE_LU12I);
        OP_PCADDU12I: code = 32'(CODE_PCADDU12I);
        OP_JIRL:      code = 32'(CODE_JIRL);
        OP_B:         code = 32'(CODE_B);
        OP_BL:        code = 32'(CODE_BL);
        OP_BEQ:       code = 32'(CODE_BEQ);
        OP_BNE:       code = 32'(CODE_BNE);
        OP_BLT:       code = 32'(CODE_BLT);
        OP_BGE:       code = 32'(CODE_BGE);
        OP_BLTU:      code = 32'(CODE_BLTU);
        OP_BGEU:      code = 32'(CODE_BGEU);
        OP_NOP:       code = CODE_NOP;
        OP_HALT:      code = CODE_HALT;
        default:      code = '1;
    endcase
endfunction

function automatic decode_exp_t model_decode(input logic [31:0] w);
    decode_exp_t e;
    int          lo;
    int          grp;
    logic [31:0] code;
    e = '0;
    e.op = OP_INVALID;
    for (int i = 0; i <= int'(OP_HALT); i++) begin
        op_field(la_op_e'(i), lo, code);
        if ((w >> lo) == code) begin
            e.op = la_op_e'(i);
        end
    end
    grp = op_group(e.op);
    if (grp == 1) begin
        e.rk = w[14:10];
    end
    if (grp >= 1 && grp <= 6) begin
        e.rj = (grp == 5) ? 5'd0 : w[9:5];
        e.rd = w[4:0];
    end
    if (e.op == OP_BL) begin
        e.rd = 5'd1;
    end
    case (grp)
        2: e.imm = {27'b0, w[14:10]};
        3: e.imm = {{20{w[21]}}, w[21:10]};
        4: e.imm = {20'b0, w[21:10]};
        5: e.imm = {{12{w[24]}}, w[24:5]};
        6: e.imm = {{14{w[25]}}, w[25:10], 2'b00};
        7: e.imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        default: e.imm = '0;
    endcase
    return e;
endfunction

// Mostly a known opcode over random bits, now and then a raw word
function automatic logic [31:0] build_inst();
    la_op_e      pick;
    int          lo;
    logic [31:0] code;
    logic [31:0] w;
    w = $urandom;
    if ($urandom_range(7) == 0) begin
        return w;
    end
    pick = la_op_e'($urandom_range(int'(OP_HALT)));
    op_field(pick, lo, code);
    if (lo == 0) begin
        return code;
    end
    w = (w & ~(32'hffff_ffff << lo)) | (code << lo);
    return w;
endfunction

`endif

//--- bench/la_decode_tb.sv
`timescale 1ns/1ps

module la_decode_tb;
    import la_decode_pkg::*;

    `include "decode_model.svh"

    localparam int NUM_CYCLES    = 3000;
    localparam int DRAIN_TIMEOUT = 20;

    logic              clk;
    logic              rst;
    logic              inst_valid;
    logic [INST_W-1:0] inst;
    logic              out_valid;
    la_op_e            op;
    logic [REG_W-1:0]  rk;
    logic [REG_W-1:0]  rj;
    logic [REG_W-1:0]  rd;
    logic [IMM_W-1:0]  imm;

    decode_exp_t exp_q[$];
    decode_exp_t last_out;
    logic        prev_valid;
    int          errors;
    int          n_checked;

    la_decode_stage dut0 (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_valid  (out_valid),
        .op         (op),
        .rk         (rk),
        .rj         (rj),
        .rd         (rd),
        .imm        (imm)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            errors++;
            $display("Mismatch %s: expected 0x%0h actual 0x%0h", name, exp_val, act_val);
        end
    endtask

    task automatic check_fields(input string tag, input decode_exp_t e);
        check_value({tag, " op"}, 32'(e.op), 32'(op));
        check_value({tag, " rk"}, 32'(e.rk), 32'(rk));
        check_value({tag, " rj"}, 32'(e.rj), 32'(rj));
        check_value({tag, " rd"}, 32'(e.rd), 32'(rd));
        check_value({tag, " imm"}, e.imm, imm);
    endtask

    // Runs 1 ns after the edge, output register already settled
    task automatic check_outputs();
        decode_exp_t e;
        check_value("out_valid", 32'(prev_valid), 32'(out_valid));
        if (out_valid) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("out_valid was high but no decoded result was expected");
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_fields("decode", e);
                last_out = e;
                n_checked++;
            end
        end else begin
            // Data outputs hold through gaps
            check_fields("hold", last_out);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic drive_cycle(input logic valid);
        logic [31:0] w;
        if (valid) begin
            w = build_inst();
            exp_q.push_back(model_decode(w));
        end else begin
            w = $urandom;
        end
        inst_valid = valid;
        inst       = w;
        prev_valid = valid;
    endtask

    initial begin
        int seed_ret;
        int timeout;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        prev_valid = 1'b0;
        errors     = 0;
        n_checked  = 0;
        last_out    = '0;
        last_out.op = OP_INVALID;
        seed_ret = $urandom(32'h2b7c);

        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state before any valid input
        check_value("reset out_valid", 32'd0, 32'(out_valid));
        check_fields("reset", last_out);

        // Roughly 3 of 4 cycles valid
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_cycle($urandom_range(3) != 0);
        end

        timeout = 0;
        do begin
            @(posedge clk);
            #1;
            check_outputs();
            drive_cycle(1'b0);
            timeout++;
        end while (exp_q.size() > 0 && timeout < DRAIN_TIMEOUT);

        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d decoded results never came out within %0d cycles after the last input",
                     exp_q.size(), DRAIN_TIMEOUT);
        end

        $display("Checked %0d results, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [la_decode_pkg::INST_W-1:0] inst,
    input  la_decode_pkg::la_op_e            op,
    output logic [la_decode_pkg::IMM_W-1:0]  imm
);
    import la_decode_pkg::*;

    logic [IMM_W-1:0] imm_ui5;
    logic [IMM_W-1:0] imm_si12;
    logic [IMM_W-1:0] imm_ui12;
    logic [IMM_W-1:0] imm_si20;
    logic [IMM_W-1:0] imm_offs16;
    logic [IMM_W-1:0] imm_offs26;

    ////////////////////////////////////////
    // Candidate immediates
    ////////////////////////////////////////
    assign imm_ui5  = {27'b0, inst[14:10]};
    assign imm_si12 = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui12 = {20'b0, inst[21:10]};
    // Left unshifted, the execute stage adds the 12 zero bits
    assign imm_si20 = {{12{inst[24]}}, inst[24:5]};

    // Word offsets
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    // High half of offs26 sits in bits 9..0
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    ////////////////////////////////////////
    // Select by operation
    ////////////////////////////////////////
    always_comb begin
        case (op)
            OP_SLLI, OP_SRLI, OP_SRAI:
                imm = imm_ui5;
            OP_ADDI, OP_SLTI, OP_SLTUI,
            OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU,
            OP_STB, OP_STH, OP_STW:
                imm = imm_si12;
            OP_ANDI, OP_ORI, OP_XORI:
                imm = imm_ui12;
            OP_LU12I, OP_PCADDU12I:
                imm = imm_si20;
            OP_JIRL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                imm = imm_offs16;
            OP_B, OP_BL:
                imm = imm_offs26;
            default:
                imm = '0;
        endcase
    end

endmodule

//--- design/inst_classifier.sv
`timescale 1ns/1ps

module inst_classifier (
    input  logic [la_decode_pkg::INST_W-1:0] inst,
    output la_decode_pkg::la_op_e            op
);
    import la_decode_pkg::*;

    // Codes of different widths never alias, so case order is free
    always_comb begin
        op = OP_INVALID;

        case (inst[31:15])
            CODE_ADD:  op = OP_ADD;
            CODE_SUB:  op = OP_SUB;
            CODE_SLT:  op = OP_SLT;
            CODE_SLTU: op = OP_SLTU;
            CODE_NOR:  op = OP_NOR;
            CODE_AND:  op = OP_AND;
            CODE_OR:   op = OP_OR;
            CODE_XOR:  op = OP_XOR;
            CODE_SLL:  op = OP_SLL;
            CODE_SRL:  op = OP_SRL;
            CODE_SRA:  op = OP_SRA;
            CODE_SLLI: op = OP_SLLI;
            CODE_SRLI: op = OP_SRLI;
            CODE_SRAI: op = OP_SRAI;
            default: ;
        endcase

        case (inst[31:22])
            CODE_SLTI:  op = OP_SLTI;
            CODE_SLTUI: op = OP_SLTUI;
            CODE_ADDI:  op = OP_ADDI;
            CODE_ANDI:  op = OP_ANDI;
            CODE_ORI:   op = OP_ORI;
            CODE_XORI:  op = OP_XORI;
            CODE_LDB:   op = OP_LDB;
            CODE_LDH:   op = OP_LDH;
            CODE_LDW:   op = OP_LDW;
            CODE_STB:   op = OP_STB;
            CODE_STH:   op = OP_STH;
            CODE_STW:   op = OP_STW;
            CODE_LDBU:  op = OP_LDBU;
            CODE_LDHU:  op = OP_LDHU;
            default: ;
        endcase

        case (inst[31:25])
            CODE_LU12I:     op = OP_LU12I;
            CODE_PCADDU12I: op = OP_PCADDU12I;
            default: ;
        endcase

        case (inst[31:26])
            CODE_JIRL: op = OP_JIRL;
            CODE_B:    op = OP_B;
            CODE_BL:   op = OP_BL;
            CODE_BEQ:  op = OP_BEQ;
            CODE_BNE:  op = OP_BNE;
            CODE_BLT:  op = OP_BLT;
            CODE_BGE:  op = OP_BGE;
            CODE_BLTU: op = OP_BLTU;
            CODE_BGEU: op = OP_BGEU;
            default: ;
        endcase

        // Full-word encodings
        if (inst == CODE_NOP) begin
            op = OP_NOP;
        end else if (inst == CODE_HALT) begin
            op = OP_HALT;
        end
    end

endmodule

//--- design/la_decode_pkg.sv
package la_decode_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int INST_W = 32;
    localparam int REG_W  = 5;
    localparam int IMM_W  = 32;

    ////////////////////////////////////////
    // Opcode fields
    ////////////////////////////////////////

    // Bits 31..15, 3R and shift-immediate
    localparam logic [16:0] CODE_ADD  = 17'h00020;
    localparam logic [16:0] CODE_SUB  = 17'h00022;
    localparam logic [16:0] CODE_SLT  = 17'h00024;
    localparam logic [16:0] CODE_SLTU = 17'h00025;
    localparam logic [16:0] CODE_NOR  = 17'h00028;
    localparam logic [16:0] CODE_AND  = 17'h00029;
    localparam logic [16:0] CODE_OR   = 17'h0002a;
    localparam logic [16:0] CODE_XOR  = 17'h0002b;
    localparam logic [16:0] CODE_SLL  = 17'h0002e;
    localparam logic [16:0] CODE_SRL  = 17'h0002f;
    localparam logic [16:0] CODE_SRA  = 17'h00030;
    localparam logic [16:0] CODE_SLLI = 17'h00081;
    localparam logic [16:0] CODE_SRLI = 17'h00089;
    localparam logic [16:0] CODE_SRAI = 17'h00091;

    // Bits 31..22, 12-bit immediate forms
    localparam logic [9:0] CODE_SLTI  = 10'h008;
    localparam logic [9:0] CODE_SLTUI = 10'h009;
    localparam logic [9:0] CODE_ADDI  = 10'h00a;
    localparam logic [9:0] CODE_ANDI  = 10'h00d;
    localparam logic [9:0] CODE_ORI   = 10'h00e;
    localparam logic [9:0] CODE_XORI  = 10'h00f;
    localparam logic [9:0] CODE_LDB   = 10'h0a0;
    localparam logic [9:0] CODE_LDH   = 10'h0a1;
    localparam logic [9:0] CODE_LDW   = 10'h0a2;
    localparam logic [9:0] CODE_STB   = 10'h0a4;
    localparam logic [9:0] CODE_STH   = 10'h0a5;
    localparam logic [9:0] CODE_STW   = 10'h0a6;
    localparam logic [9:0] CODE_LDBU  = 10'h0a8;
    localparam logic [9:0] CODE_LDHU  = 10'h0a9;

    // Bits 31..25
    localparam logic [6:0] CODE_LU12I     = 7'h0a;
    localparam logic [6:0] CODE_PCADDU12I = 7'h0e;

    // Bits 31..26, jumps and branches
    localparam logic [5:0] CODE_JIRL = 6'h13;
    localparam logic [5:0] CODE_B    = 6'h14;
    localparam logic [5:0] CODE_BL   = 6'h15;
    localparam logic [5:0] CODE_BEQ  = 6'h16;
    localparam logic [5:0] CODE_BNE  = 6'h17;
    localparam logic [5:0] CODE_BLT  = 6'h18;
    localparam logic [5:0] CODE_BGE  = 6'h19;
    localparam logic [5:0] CODE_BLTU = 6'h1a;
    localparam logic [5:0] CODE_BGEU = 6'h1b;

    // Whole word
    localparam logic [31:0] CODE_NOP  = 32'h0000_0000;
    localparam logic [31:0] CODE_HALT = 32'h8000_0000;

    ////////////////////////////////////////
    // Decoded operation
    ////////////////////////////////////////
    typedef enum logic [5:0] {
        OP_ADD       = 6'h00, OP_ADDI      = 6'h01, OP_SUB       = 6'h02,
        OP_LU12I     = 6'h03, OP_PCADDU12I = 6'h04, OP_SLT       = 6'h05,
        OP_SLTU      = 6'h06, OP_SLTI      = 6'h07, OP_SLTUI     = 6'h08,
        OP_AND       = 6'h09, OP_ANDI      = 6'h0a, OP_OR        = 6'h0b,
        OP_ORI       = 6'h0c, OP_NOR       = 6'h0d, OP_XOR       = 6'h0e,
        OP_XORI      = 6'h0f, OP_SLL       = 6'h10, OP_SLLI      = 6'h11,
        OP_SRL       = 6'h12, OP_SRLI      = 6'h13, OP_SRA       = 6'h14,
        OP_SRAI      = 6'h15, OP_STW       = 6'h16, OP_STH       = 6'h17,
        OP_STB       = 6'h18, OP_LDW       = 6'h19, OP_LDH       = 6'h1a,
        OP_LDB       = 6'h1b, OP_LDHU      = 6'h1c, OP_LDBU      = 6'h1d,
        OP_BEQ       = 6'h1e, OP_BNE       = 6'h1f, OP_BLT       = 6'h20,
        OP_BGE       = 6'h21, OP_BLTU      = 6'h22, OP_BGEU      = 6'h23,
        OP_B         = 6'h24, OP_BL        = 6'h25, OP_JIRL      = 6'h26,
        OP_NOP       = 6'h27, OP_HALT      = 6'h28,
        // No code matched
        OP_INVALID   = 6'h29
    } la_op_e;

endpackage

//--- design/la_decode_stage.sv
`timescale 1ns/1ps

module la_decode_stage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             inst_valid,
    input  logic [la_decode_pkg::INST_W-1:0] inst,
    output logic                             out_valid,
    output la_decode_pkg::la_op_e            op,
    output logic [la_decode_pkg::REG_W-1:0]  rk,
    output logic [la_decode_pkg::REG_W-1:0]  rj,
    output logic [la_decode_pkg::REG_W-1:0]  rd,
    output logic [la_decode_pkg::IMM_W-1:0]  imm
);
    import la_decode_pkg::*;

    la_op_e           op_next;
    logic [REG_W-1:0] rk_next;
    logic [REG_W-1:0] rj_next;
    logic [REG_W-1:0] rd_next;
    logic [IMM_W-1:0] imm_next;

    inst_classifier u_classifier (
        .inst (inst),
        .op   (op_next)
    );

    reg_field_select u_reg_sel (
        .inst (inst),
        .op   (op_next),
        .rk   (rk_next),
        .rj   (rj_next),
        .rd   (rd_next)
    );

    imm_gen u_imm_gen (
        .inst (inst),
        .op   (op_next),
        .imm  (imm_next)
    );

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            op        <= OP_INVALID;
            rk        <= '0;
            rj        <= '0;
            rd        <= '0;
            imm       <= '0;
        end else begin
            out_valid <= inst_valid;
            // Hold the last result through gaps
            if (inst_valid) begin
                op  <= op_next;
                rk  <= rk_next;
                rj  <= rj_next;
                rd  <= rd_next;
                imm <= imm_next;
            end
        end
    end

    a_valid_latency: assert property (@(posedge clk) !rst |=> out_valid == $past(inst_valid))
        else $error("la_decode_stage: out_valid lost its one-cycle relation to inst_valid");

    // Classifier and field decoders must agree on the fieldless operations
    a_fieldless_zero: assert property (@(posedge clk)
        (op inside {OP_INVALID, OP_NOP, OP_HALT}) |-> (rk == '0 && rj == '0 && rd == '0 && imm == '0))
        else $error("la_decode_stage: nonzero field on op 0x%0h", op);

endmodule

//--- design/reg_field_select.sv
`timescale 1ns/1ps

module reg_field_select (
    input  logic [la_decode_pkg::INST_W-1:0] inst,
    input  la_decode_pkg::la_op_e            op,
    output logic [la_decode_pkg::REG_W-1:0]  rk,
    output logic [la_decode_pkg::REG_W-1:0]  rj,
    output logic [la_decode_pkg::REG_W-1:0]  rd
);
    import la_decode_pkg::*;

    logic fmt_3r;
    logic fmt_2ri;
    logic fmt_1ri20;

    // Format groups
    always_comb begin
        fmt_3r = op inside {OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR,
                            OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
        // 2RI5, 2RI12 and 2RI16 all carry rj and rd
        fmt_2ri = op inside {OP_SLLI, OP_SRLI, OP_SRAI,
                             OP_SLTI, OP_SLTUI, OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
                             OP_LDB, OP_LDH, OP_LDW, OP_LDBU, OP_LDHU,
                             OP_STB, OP_STH, OP_STW,
                             OP_JIRL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        fmt_1ri20 = op inside {OP_LU12I, OP_PCADDU12I};
    end

    assign rk = fmt_3r ? inst[14:10] : '0;
    assign rj = (fmt_3r || fmt_2ri) ? inst[9:5] : '0;

    always_comb begin
        if (op == OP_BL) begin
            // Link register
            rd = REG_W'(1);
        end else if (fmt_3r || fmt_2ri || fmt_1ri20) begin
            rd = inst[4:0];
        end else begin
            rd = '0;
        end
    end

endmodule

//--- files.f
+incdir+include
design/la_decode_pkg.sv
design/inst_classifier.sv
design/reg_field_select.sv
design/imm_gen.sv
design/la_decode_stage.sv
bench/la_decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module la_decode_tb -o la_decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/la_decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    exit 1
fi
exit 0
